// File: verilog/ecc_cfg_pkg.sv
package ecc_cfg_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // port widths and code modes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int max_cw_width   = 32;
    localparam int max_info_width = 26;
    localparam int max_syn_width  = 5;   // hamming check bits of the widest mode

    typedef enum logic [1:0] {
        mode_8_4   = 2'd0,
        mode_16_11 = 2'd1,
        mode_32_26 = 2'd2,
        mode_none  = 2'd3   // reserved
    } code_mode_t;

    localparam int info_w_8_4   = 4;
    localparam int info_w_16_11 = 11;
    localparam int info_w_32_26 = 26;
    localparam int par_w_8_4    = 4;   // check bits + overall bit
    localparam int par_w_16_11  = 5;
    localparam int par_w_32_26  = 6;
    localparam int cw_w_8_4     = info_w_8_4 + par_w_8_4;
    localparam int cw_w_16_11   = info_w_16_11 + par_w_16_11;
    localparam int cw_w_32_26   = info_w_32_26 + par_w_32_26;

    function automatic int info_width_of(input code_mode_t mode);
        case (mode)
            mode_8_4:   return info_w_8_4;
            mode_16_11: return info_w_16_11;
            mode_32_26: return info_w_32_26;
            default:    return 0;
        endcase
    endfunction

    function automatic int par_width_of(input code_mode_t mode);
        case (mode)
            mode_8_4:   return par_w_8_4;
            mode_16_11: return par_w_16_11;
            mode_32_26: return par_w_32_26;
            default:    return 0;
        endcase
    endfunction

    function automatic int cw_width_of(input code_mode_t mode);
        return info_width_of(mode) + par_width_of(mode);
    endfunction

    function automatic int syn_width_of(input code_mode_t mode);
        return (mode == mode_none) ? 0 : par_width_of(mode) - 1;
    endfunction

    // j-th integer from 3 upward that is not a power of two
    function automatic logic [max_syn_width-1:0] info_column(input int j);
        int n;
        logic [max_syn_width-1:0] col;
        n = 0;
        col = '0;
        for (int c = 3; c < (1 << max_syn_width); c++) begin
            if ((c & (c - 1)) != 0) begin
                if (n == j) col = max_syn_width'(c);
                n++;
            end
        end
        return col;
    endfunction

endpackage

// File: verilog/ecc_pipe_pkg.sv
package ecc_pipe_pkg;

    typedef enum logic [1:0] {
        err_none   = 2'd0,
        err_single = 2'd1,
        err_double = 2'd2
    } err_count_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decoder stage registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        ecc_cfg_pkg::code_mode_t                  mode;
        logic [ecc_cfg_pkg::max_cw_width-1:0]     cw;      // received word
        logic [ecc_cfg_pkg::max_syn_width-1:0]    syn;
        logic                                     overall; // xor over mode width
    } syn_stage_t;

    typedef struct packed {
        ecc_cfg_pkg::code_mode_t                  mode;
        logic [ecc_cfg_pkg::max_cw_width-1:0]     cw;      // after correction
        err_count_t                               errs;
    } cor_stage_t;

    localparam syn_stage_t syn_idle = '{
        mode:    ecc_cfg_pkg::mode_none,
        cw:      '0,
        syn:     '0,
        overall: 1'b0
    };

    localparam cor_stage_t cor_idle = '{
        mode: ecc_cfg_pkg::mode_none,
        cw:   '0,
        errs: err_none
    };

endpackage

// File: verilog/ecc_encoder.sv
`timescale 1ns/100ps

module ecc_encoder (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [ecc_cfg_pkg::max_info_width-1:0] data_in,
    input  ecc_cfg_pkg::code_mode_t               work_mod,
    output logic [ecc_cfg_pkg::max_cw_width-1:0]   codeword
);
    import ecc_cfg_pkg::*;

    logic [max_info_width-1:0] info;
    logic [max_syn_width-1:0]  check;
    logic [max_cw_width-1:0]   cw_next;
    int                        k;
    int                        r;

    always_comb begin
        k = info_width_of(work_mod);
        r = syn_width_of(work_mod);
        for (int j = 0; j < max_info_width; j++)
            info[j] = data_in[j] & (j < k);  // drop bits above the mode width

        check = '0;
        for (int j = 0; j < max_info_width; j++)
            if (info[j]) check ^= info_column(j);

        // mode_none has k = r = 0, so everything below stays zero
        cw_next    = max_cw_width'(check);
        cw_next[r] = ^{info, check};  // overall bit gives even parity
        cw_next    = cw_next | (max_cw_width'(info) << (r + 1));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            codeword <= '0;
        end else begin
            codeword <= cw_next;
        end
    end

    a_even_parity: assert property (@(posedge clk) disable iff (rst)
        (work_mod != mode_none) |=> (^codeword == 1'b0));

endmodule

// File: verilog/dec_syndrome.sv
`timescale 1ns/100ps

module dec_syndrome (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [ecc_cfg_pkg::max_cw_width-1:0] rx_codeword,
    input  ecc_cfg_pkg::code_mode_t             rx_mode,
    output ecc_pipe_pkg::syn_stage_t            syn_out
);
    import ecc_cfg_pkg::*;
    import ecc_pipe_pkg::*;

    syn_stage_t                syn_d;
    logic [max_cw_width-1:0]   cw_mask;
    logic [max_info_width-1:0] rx_info;
    logic [max_syn_width-1:0]  recomp;
    logic [max_syn_width-1:0]  syn_mask;
    int                        k;
    int                        r;
    int                        n;

    always_comb begin
        k = info_width_of(rx_mode);
        r = syn_width_of(rx_mode);
        n = cw_width_of(rx_mode);
        for (int b = 0; b < max_cw_width; b++)
            cw_mask[b] = (b < n);
        for (int i = 0; i < max_syn_width; i++)
            syn_mask[i] = (i < r);

        rx_info = max_info_width'(rx_codeword >> (r + 1));

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // recompute check bits from the received info
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        recomp = '0;
        for (int j = 0; j < max_info_width; j++)
            if (j < k && rx_info[j]) recomp ^= info_column(j);

        // mode_none masks to zero width, so cw, syn and overall all come out zero
        syn_d.mode    = rx_mode;
        syn_d.cw      = rx_codeword & cw_mask;
        syn_d.syn     = (rx_codeword[max_syn_width-1:0] ^ recomp) & syn_mask;
        syn_d.overall = ^(rx_codeword & cw_mask);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            syn_out <= syn_idle;
        end else begin
            syn_out <= syn_d;
        end
    end

endmodule

// File: verilog/dec_correct.sv
`timescale 1ns/100ps

module dec_correct (
    input  logic                     clk,
    input  logic                     rst,
    input  ecc_pipe_pkg::syn_stage_t syn_in,
    output ecc_pipe_pkg::cor_stage_t cor_out
);
    import ecc_cfg_pkg::*;
    import ecc_pipe_pkg::*;

    cor_stage_t              cor_d;
    logic [max_cw_width-1:0] flip_mask;
    int                      k;
    int                      r;

    always_comb begin
        k = info_width_of(syn_in.mode);
        r = syn_width_of(syn_in.mode);
        flip_mask  = '0;
        cor_d.mode = syn_in.mode;
        cor_d.errs = err_none;

        if (syn_in.overall) begin
            // odd parity means one bit flipped
            cor_d.errs = err_single;
            flip_mask  = max_cw_width'(1) << r;  // zero syndrome hits the overall bit
            for (int i = 0; i < max_syn_width; i++)
                if (syn_in.syn == (max_syn_width'(1) << i))
                    flip_mask = max_cw_width'(1) << i;  // check bit
            for (int j = 0; j < max_info_width; j++)
                if (j < k && syn_in.syn == info_column(j))
                    flip_mask = max_cw_width'(1) << (r + 1 + j);
        end else if (syn_in.syn != '0) begin
            cor_d.errs = err_double;  // even parity with a nonzero syndrome
        end

        cor_d.cw = syn_in.cw ^ flip_mask;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cor_out <= cor_idle;
        end else begin
            cor_out <= cor_d;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_errs_legal: assert property (@(posedge clk) disable iff (rst)
        cor_out.errs inside {err_none, err_single, err_double});

    a_double_untouched: assert property (@(posedge clk) disable iff (rst)
        (!syn_in.overall && syn_in.syn != '0)
            |=> (cor_out.errs == err_double && cor_out.cw == $past(syn_in.cw)));

endmodule

// File: verilog/dec_extract.sv
`timescale 1ns/100ps

module dec_extract (
    input  logic                                  clk,
    input  logic                                  rst,
    input  ecc_pipe_pkg::cor_stage_t              cor_in,
    output logic [ecc_cfg_pkg::max_info_width-1:0] data_out,
    output ecc_pipe_pkg::err_count_t              num_of_errors
);
    import ecc_cfg_pkg::*;
    import ecc_pipe_pkg::*;

    logic [max_info_width-1:0] info_d;

    // info field sits right above the parity field
    always_comb begin
        case (cor_in.mode)
            mode_8_4:   info_d = max_info_width'(cor_in.cw[cw_w_8_4-1:par_w_8_4]);
            mode_16_11: info_d = max_info_width'(cor_in.cw[cw_w_16_11-1:par_w_16_11]);
            mode_32_26: info_d = cor_in.cw[cw_w_32_26-1:par_w_32_26];
            default:    info_d = '0;
        endcase
    end

    // errs is already err_none for mode_none, the earlier stages see a zero word
    always_ff @(posedge clk) begin
        if (rst) begin
            data_out      <= '0;
            num_of_errors <= err_none;
        end else begin
            data_out      <= info_d;
            num_of_errors <= cor_in.errs;
        end
    end

endmodule

// File: verilog/ecc_codec.sv
`timescale 1ns/100ps

module ecc_codec (
    input  logic                                  clk,
    input  logic                                  rst,
    // encoder side
    input  logic [ecc_cfg_pkg::max_info_width-1:0] data_in,
    input  ecc_cfg_pkg::code_mode_t               work_mod,
    output logic [ecc_cfg_pkg::max_cw_width-1:0]   codeword,
    // decoder side
    input  logic [ecc_cfg_pkg::max_cw_width-1:0]   rx_codeword,
    input  ecc_cfg_pkg::code_mode_t               rx_mode,
    output logic [ecc_cfg_pkg::max_info_width-1:0] data_out,
    output ecc_pipe_pkg::err_count_t              num_of_errors
);
    import ecc_pipe_pkg::*;

    syn_stage_t syn_q;
    cor_stage_t cor_q;

    ecc_encoder u_encoder (
        .clk      (clk),
        .rst      (rst),
        .data_in  (data_in),
        .work_mod (work_mod),
        .codeword (codeword)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 3 stage decoder
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    dec_syndrome u_syndrome (
        .clk         (clk),
        .rst         (rst),
        .rx_codeword (rx_codeword),
        .rx_mode     (rx_mode),
        .syn_out     (syn_q)
    );

    dec_correct u_correct (
        .clk     (clk),
        .rst     (rst),
        .syn_in  (syn_q),
        .cor_out (cor_q)
    );

    dec_extract u_extract (
        .clk           (clk),
        .rst           (rst),
        .cor_in        (cor_q),
        .data_out      (data_out),
        .num_of_errors (num_of_errors)
    );

endmodule

// File: test/tb_ecc_codec.sv
`timescale 1ns/100ps

module tb_ecc_codec;
    import ecc_cfg_pkg::*;
    import ecc_pipe_pkg::*;

    typedef struct packed {
        logic                      valid;
        logic [2:0]                tid;
        logic [max_cw_width-1:0]   cw;     // expected codeword
        logic [max_info_width-1:0] data;   // expected decoder data
        err_count_t                errs;
    } expect_t;

    typedef struct packed {
        logic [max_info_width-1:0] data;
        err_count_t                errs;
    } dec_res_t;

    logic                      clk;
    logic                      rst;
    logic [max_info_width-1:0] data_in;
    code_mode_t                work_mod;
    logic [max_cw_width-1:0]   codeword;
    logic [max_cw_width-1:0]   rx_codeword;
    code_mode_t                rx_mode;
    logic [max_info_width-1:0] data_out;
    err_count_t                num_of_errors;

    expect_t     cur;
    expect_t     enc_q;
    expect_t     dec_q1;
    expect_t     dec_q2;
    expect_t     dec_q3;
    logic [31:0] rng_state;
    int          error_count;
    int          check_count;
    int          test_errs[6];
    int          test_checks[6];

    ecc_codec uut (
        .clk           (clk),
        .rst           (rst),
        .data_in       (data_in),
        .work_mod      (work_mod),
        .codeword      (codeword),
        .rx_codeword   (rx_codeword),
        .rx_mode       (rx_mode),
        .data_out      (data_out),
        .num_of_errors (num_of_errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic int data_bits(input code_mode_t m);
        case (m)
            mode_8_4:   return 4;
            mode_16_11: return 11;
            mode_32_26: return 26;
            default:    return 0;
        endcase
    endfunction

    function automatic int check_bits(input code_mode_t m);
        return (data_bits(m) == 0) ? 0 : (m == mode_8_4) ? 3 : (m == mode_16_11) ? 4 : 5;
    endfunction

    // j-th non power of two counting from 3
    function automatic int col_of(input int j);
        int c;
        int seen;
        c = 2;
        seen = -1;
        while (seen < j) begin
            c++;
            if ((c & (c - 1)) != 0) seen++;
        end
        return c;
    endfunction

    function automatic logic [31:0] ref_encode(input logic [25:0] info, input code_mode_t m);
        int          k;
        int          r;
        int          col;
        logic [31:0] cw;
        k = data_bits(m);
        r = check_bits(m);
        cw = '0;
        for (int j = 0; j < k; j++) begin
            if (info[j]) begin
                col = col_of(j);
                for (int i = 0; i < r; i++)
                    if (col[i]) cw[i] = ~cw[i];
                cw[r + 1 + j] = 1'b1;
            end
        end
        if (k != 0) cw[r] = ^cw;  // even overall parity
        return cw;
    endfunction

    function automatic dec_res_t ref_decode(input logic [31:0] rx, input code_mode_t m);
        int          k;
        int          r;
        int          col;
        logic [31:0] w;
        logic [4:0]  syn;
        dec_res_t    res;
        k = data_bits(m);
        r = check_bits(m);
        w = '0;
        for (int b = 0; b < k + r + 1 && k != 0; b++) w[b] = rx[b];
        syn = '0;
        for (int i = 0; i < r; i++) begin
            syn[i] = w[i];
            for (int j = 0; j < k; j++) begin
                col = col_of(j);
                if (col[i] && w[r + 1 + j]) syn[i] = ~syn[i];
            end
        end
        res.errs = err_none;
        if (^w) begin
            res.errs = err_single;
            if (syn == '0) begin
                w[r] = ~w[r];
            end else begin
                for (int i = 0; i < r; i++)
                    if (syn == (5'd1 << i)) w[i] = ~w[i];
                for (int j = 0; j < k; j++)
                    if (col_of(j) == int'(syn)) w[r + 1 + j] = ~w[r + 1 + j];
            end
        end else if (syn != '0) begin
            res.errs = err_double;
        end
        res.data = '0;
        for (int j = 0; j < k; j++) res.data[j] = w[r + 1 + j];
        return res;
    endfunction

    // flips count distinct bits inside the mode width
    function automatic logic [31:0] corrupt(input logic [31:0] cw, input code_mode_t m,
                                            input int count);
        int          n;
        int          p1;
        int          p2;
        logic [31:0] w;
        n = data_bits(m) + check_bits(m) + 1;
        w = cw;
        p1 = int'(next_rand() % 32'(n));
        if (count > 0) w[p1] = ~w[p1];
        if (count > 1) begin
            p2 = (p1 + 1 + int'(next_rand() % 32'(n - 1))) % n;
            w[p2] = ~w[p2];
        end
        return w;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want,
                         input int tid);
        check_count++;
        test_checks[tid]++;
        if (got !== want) begin
            error_count++;
            test_errs[tid]++;
            $display("FAILED %s: got 0x%h, expected 0x%h (test %0d)", name, got, want, tid + 1);
        end
    endtask

    // 1 stage for the encoder, 3 for the decoder
    always @(posedge clk) begin
        enc_q  <= cur;
        dec_q1 <= cur;
        dec_q2 <= dec_q1;
        dec_q3 <= dec_q2;
    end

    always @(negedge clk) begin
        if (enc_q.valid) check("codeword", codeword, enc_q.cw, int'(enc_q.tid));
        if (dec_q3.valid) begin
            check("data_out", 32'(data_out), 32'(dec_q3.data), int'(dec_q3.tid));
            check("num_of_errors", 32'(num_of_errors), 32'(dec_q3.errs), int'(dec_q3.tid));
        end
    end

    task automatic drive(input int tid, input logic [25:0] info, input code_mode_t m,
                         input logic [31:0] rx, input code_mode_t rm, input dec_res_t e);
        data_in     = info;
        work_mod    = m;
        rx_codeword = rx;
        rx_mode     = rm;
        cur.valid   = 1'b1;
        cur.tid     = 3'(tid);
        cur.cw      = ref_encode(info, m);
        cur.data    = e.data;
        cur.errs    = e.errs;
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input int tid, input string name);
        data_in     = '0;
        work_mod    = mode_none;
        rx_codeword = '0;
        rx_mode     = mode_none;
        cur         = '0;
        repeat (4) @(posedge clk);  // decoder latency plus one
        #1;
        $display("test %0d %s: %0d checks, %0d errors", tid + 1, name, test_checks[tid],
                 test_errs[tid]);
    endtask

    task automatic run_test(input int tid, input string name, input int count);
        logic [25:0] info;
        logic [31:0] cw;
        logic [31:0] rx;
        code_mode_t  m;
        dec_res_t    e;
        for (int i = 0; i < count; i++) begin
            info = 26'(next_rand());
            if (tid == 1 || tid == 5) m = code_mode_t'(2'(i % 4));  // every mode in turn
            else m = code_mode_t'(2'(next_rand() % 3));
            cw = ref_encode(info, m);
            e.data = info & ((26'd1 << data_bits(m)) - 26'd1);
            e.errs = (tid == 3) ? err_single : err_none;
            case (tid)
                1: begin
                    rx = '0;
                    e  = '0;
                end
                2: rx = cw;
                3: rx = corrupt(cw, m, 1);
                4: begin
                    rx = corrupt(cw, m, 2);
                    e  = ref_decode(rx, m);
                end
                default: begin
                    rx = (m == mode_none) ? next_rand() : corrupt(cw, m, int'(next_rand() % 3));
                    e  = ref_decode(rx, m);
                end
            endcase
            drive(tid, info, m, rx, (tid == 1) ? mode_none : m, e);
        end
        finish_test(tid, name);
    endtask

    initial begin
        int n;
        // busy words go in while rst is held
        data_in     = '1;
        work_mod    = mode_32_26;
        rx_codeword = '1;
        rx_mode     = mode_32_26;
        cur         = '0;
        rng_state   = 32'hb33b4f13;
        error_count = 0;
        check_count = 0;
        n = 0;
        while (rst !== 1'b0 && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            $display("timeout: reset was never released");
            $display("Errors found");
            $finish;
        end else begin
            // outputs still hold what the last reset edge left
            check("codeword", codeword, '0, 0);
            check("data_out", 32'(data_out), '0, 0);
            check("num_of_errors", 32'(num_of_errors), '0, 0);
            @(posedge clk);
            #1;
            finish_test(0, "reset");
            run_test(1, "encode", 60);
            run_test(2, "clean round trip", 60);
            run_test(3, "single error", 80);
            run_test(4, "double error", 80);
            run_test(5, "mode changes", 64);
            $display("total: %0d checks, %0d errors", check_count, error_count);
            if (error_count == 0)
                $display("No errors");
            else
                $display("Errors found");
            $finish;
        end
    end

endmodule

// File: all.f
verilog/ecc_cfg_pkg.sv
verilog/ecc_pipe_pkg.sv
verilog/ecc_encoder.sv
verilog/dec_syndrome.sv
verilog/dec_correct.sv
verilog/dec_extract.sv
verilog/ecc_codec.sv
test/tb_ecc_codec.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_ecc_codec \
    -Mdir obj_dir -o sim_ecc_codec

./obj_dir/sim_ecc_codec | tee sim.log

if grep -q "^No errors$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
